// File: common/board_pkg.sv
// ==================================================
// Board test register map and host bus widths
// Control word decoded raw by the bus, by field in hardware
// ==================================================
`default_nettype none

package board_pkg;

	// Wishbone word address and data widths
	localparam int WB_ADDR_W = 4;
	localparam int WB_DATA_W = 32;

	// Register word addresses
	localparam logic [WB_ADDR_W-1:0] REG_CTRL      = 4'd0;
	localparam logic [WB_ADDR_W-1:0] REG_PERIOD    = 4'd1;
	localparam logic [WB_ADDR_W-1:0] REG_SRC_LO    = 4'd2;
	localparam logic [WB_ADDR_W-1:0] REG_FRAME_CNT = 4'd3;
	localparam logic [WB_ADDR_W-1:0] REG_ID        = 4'd4;

	// Identification word, read only
	localparam logic [WB_DATA_W-1:0] BOARD_ID = 32'h4254_0001;

	// Reset values of the configuration registers
	localparam logic [WB_DATA_W-1:0] PERIOD_RESET = 32'd1023;
	localparam logic [7:0]           SRC_LO_RESET = 8'h01;

	// Control word as seen by the frame generator and board pins
	// payload_len of 0 and anything below 46 pads to 46 bytes
	typedef struct packed {
		logic [4:0] reserved;
		logic       vcxo_off;
		logic       pmod_oe;
		logic       gen_enable;
		logic [7:0] leds;
		logic [7:0] payload_seed;
		logic [7:0] payload_len;
	} ctrl_fields_t;

	// Raw bus view and decoded field view of the same word
	typedef union packed {
		logic [WB_DATA_W-1:0] raw;
		ctrl_fields_t         fields;
	} ctrl_reg_t;

endpackage

`default_nettype wire

// File: common/eth_pkg.sv
// ==================================================
// Ethernet test frame constants and field lengths
// ==================================================
`default_nettype none

package eth_pkg;

	// Preamble and start of frame delimiter
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam int         PREAMBLE_LEN  = 7;
	localparam logic [7:0] SFD_BYTE      = 8'hD5;

	// Header fields, sent most significant byte first
	localparam logic [47:0] DEST_MAC   = 48'hFFFF_FFFF_FFFF;
	localparam logic [39:0] SRC_MAC_HI = 40'h02_00_5E_10_00;
	localparam logic [15:0] ETHERTYPE  = 16'h88B5;

	// Field lengths in bytes
	localparam int         MAC_LEN     = 6;
	localparam int         TYPE_LEN    = 2;
	localparam int         FCS_LEN     = 4;
	localparam logic [7:0] MIN_PAYLOAD = 8'd46;
	localparam int         IFG_LEN     = 12;

	// Reflected CRC-32, residue of the uncomplemented register
	localparam logic [31:0] CRC_INIT    = 32'hFFFF_FFFF;
	localparam logic [31:0] CRC_POLY    = 32'hEDB8_8320;
	localparam logic [31:0] CRC_RESIDUE = 32'hDEBB_20E3;

	// Frame field sequence of the generator FSM
	localparam logic [3:0] ST_IDLE     = 4'd0;
	localparam logic [3:0] ST_PREAMBLE = 4'd1;
	localparam logic [3:0] ST_SFD      = 4'd2;
	localparam logic [3:0] ST_DEST     = 4'd3;
	localparam logic [3:0] ST_SRC      = 4'd4;
	localparam logic [3:0] ST_TYPE     = 4'd5;
	localparam logic [3:0] ST_PAYLOAD  = 4'd6;
	localparam logic [3:0] ST_FCS      = 4'd7;
	localparam logic [3:0] ST_GAP      = 4'd8;

endpackage

`default_nettype wire

// File: verilog/test_regs.sv
// ==================================================
// Wishbone classic register bank for board bring-up
// Drives LEDs, Pmod enable, VCXO enable and generator setup
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module test_regs import board_pkg::*; (
	input  wire logic                 tx_clk,
	input  wire logic                 rst,
	input  wire logic                 wb_cyc,
	input  wire logic                 wb_stb,
	input  wire logic                 wb_we,
	input  wire logic [WB_ADDR_W-1:0] wb_adr,
	input  wire logic [WB_DATA_W-1:0] wb_dat_w,
	input  wire logic                 frame_done,
	output logic      [WB_DATA_W-1:0] wb_dat_r,
	output logic                      wb_ack,
	output ctrl_reg_t                 ctrl,
	output logic      [WB_DATA_W-1:0] period,
	output logic      [7:0]           src_lo,
	output logic      [7:0]           leds,
	output logic                      pmod_oe,
	output logic                      vcxo_en
);

	logic                 req;
	logic                 wr_en;
	logic [WB_DATA_W-1:0] frame_cnt;
	logic [WB_DATA_W-1:0] rd_mux;

	// New request only while ack is low, so each access acks once
	assign req   = wb_cyc && wb_stb && !wb_ack;
	assign wr_en = req && wb_we;

	// Single-cycle classic handshake
	always_ff @(posedge tx_clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= req;
		end
	end

	// Writable registers, other addresses ignore writes
	always_ff @(posedge tx_clk) begin
		if (rst) begin
			ctrl.raw <= '0;
			period   <= PERIOD_RESET;
			src_lo   <= SRC_LO_RESET;
		end else if (wr_en) begin
			case (wb_adr)
				REG_CTRL:   ctrl.raw <= wb_dat_w;
				REG_PERIOD: period   <= wb_dat_w;
				REG_SRC_LO: src_lo   <= wb_dat_w[7:0];
				default: ;
			endcase
		end
	end

	// Frames sent since reset
	always_ff @(posedge tx_clk) begin
		if (rst) begin
			frame_cnt <= '0;
		end else if (frame_done) begin
			frame_cnt <= frame_cnt + 32'd1;
		end
	end

	// Read decode, unmapped words read as zero
	always_comb begin
		case (wb_adr)
			REG_CTRL:      rd_mux = ctrl.raw;
			REG_PERIOD:    rd_mux = period;
			REG_SRC_LO:    rd_mux = {24'h0, src_lo};
			REG_FRAME_CNT: rd_mux = frame_cnt;
			REG_ID:        rd_mux = BOARD_ID;
			default:       rd_mux = '0;
		endcase
	end

	// Read data captured with the ack
	always_ff @(posedge tx_clk) begin
		if (req) begin
			wb_dat_r <= rd_mux;
		end
	end

	// Board pins from the field view
	assign leds    = ctrl.fields.leds;
	assign pmod_oe = ctrl.fields.pmod_oe;
	// VCXO runs unless the host turns it off
	assign vcxo_en = ~ctrl.fields.vcxo_off;

endmodule

`default_nettype wire

// File: frame_gen/interval_timer.sv
// ==================================================
// Frame interval timer, start pulse every period+1
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module interval_timer (
	input  wire logic        tx_clk,
	input  wire logic        rst,
	input  wire logic        enable,
	input  wire logic [31:0] period,
	output logic             start_tick
);

	logic [31:0] count;

	// Down-counter, parked at the reload value while disabled
	always_ff @(posedge tx_clk) begin
		if (rst) begin
			count      <= '0;
			start_tick <= 1'b0;
		end else if (!enable) begin
			count      <= period;
			start_tick <= 1'b0;
		end else if (count == 32'd0) begin
			// Fire and reload in the same cycle
			count      <= period;
			start_tick <= 1'b1;
		end else begin
			count      <= count - 32'd1;
			start_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: frame_gen/eth_crc32.sv
// ==================================================
// Byte-wide reflected Ethernet CRC-32
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module eth_crc32 import eth_pkg::*; (
	input  wire logic        tx_clk,
	input  wire logic        rst,
	input  wire logic        crc_clear,
	input  wire logic        crc_en,
	input  wire logic [7:0]  crc_byte,
	output logic      [31:0] crc_out
);

	logic [31:0] crc;

	// Eight LSB-first shift steps of the reflected polynomial
	function automatic logic [31:0] crc_step(input logic [31:0] cur, input logic [7:0] data);
		logic [31:0] c;
		c = cur ^ {24'h0, data};
		for (int i = 0; i < 8; i++) begin
			c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
		end
		return c;
	endfunction

	// Clear has priority over an update
	always_ff @(posedge tx_clk) begin
		if (rst || crc_clear) begin
			crc <= CRC_INIT;
		end else if (crc_en) begin
			crc <= crc_step(crc, crc_byte);
		end
	end

	// Complemented FCS, bits [7:0] are the first byte on the wire
	assign crc_out = ~crc;

endmodule

`default_nettype wire

// File: frame_gen/frame_fsm.sv
// ==================================================
// Test frame FSM, sequences fields onto GMII bytes
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module frame_fsm import eth_pkg::*; (
	input  wire logic       tx_clk,
	input  wire logic       rst,
	input  wire logic       start_tick,
	input  wire logic [7:0] payload_len,
	input  wire logic [7:0] payload_seed,
	input  wire logic [7:0] src_lo,
	output logic      [7:0] gmii_txd,
	output logic            gmii_tx_en,
	output logic            gmii_tx_er,
	output logic            frame_done
);

	logic [3:0]  state;
	logic [3:0]  field_next;
	logic [7:0]  idx;
	logic        field_last;
	logic [7:0]  len_q;
	logic [7:0]  seed_q;
	logic [7:0]  src_q;
	logic        crc_clear;
	logic        crc_en;
	logic [31:0] crc_out;

	// Byte pos of a field word, pos 0 is the low byte
	function automatic logic [7:0] field_byte(input logic [47:0] word, input logic [2:0] pos);
		logic [47:0] shifted;
		shifted = word >> {pos, 3'b000};
		return shifted[7:0];
	endfunction

	// Last byte of the current field
	always_comb begin
		case (state)
			ST_PREAMBLE:     field_last = (idx == 8'(PREAMBLE_LEN - 1));
			ST_DEST, ST_SRC: field_last = (idx == 8'(MAC_LEN - 1));
			ST_TYPE:         field_last = (idx == 8'(TYPE_LEN - 1));
			ST_PAYLOAD:      field_last = (idx == len_q - 8'd1);
			ST_FCS:          field_last = (idx == 8'(FCS_LEN - 1));
			ST_GAP:          field_last = (idx == 8'(IFG_LEN - 1));
			default:         field_last = 1'b1;
		endcase
	end

	// Field order on the wire
	always_comb begin
		case (state)
			ST_PREAMBLE: field_next = ST_SFD;
			ST_SFD:      field_next = ST_DEST;
			ST_DEST:     field_next = ST_SRC;
			ST_SRC:      field_next = ST_TYPE;
			ST_TYPE:     field_next = ST_PAYLOAD;
			ST_PAYLOAD:  field_next = ST_FCS;
			ST_FCS:      field_next = ST_GAP;
			default:     field_next = ST_IDLE;
		endcase
	end

	// Ticks outside idle are dropped, frames never overlap
	always_ff @(posedge tx_clk) begin
		if (rst) begin
			state <= ST_IDLE;
			idx   <= '0;
		end else if (state == ST_IDLE) begin
			idx <= '0;
			if (start_tick) begin
				state <= ST_PREAMBLE;
			end
		end else if (field_last) begin
			state <= field_next;
			idx   <= '0;
		end else begin
			idx <= idx + 8'd1;
		end
	end

	// Configuration held for the whole frame, short lengths padded
	always_ff @(posedge tx_clk) begin
		if (state == ST_IDLE && start_tick) begin
			len_q  <= (payload_len < MIN_PAYLOAD) ? MIN_PAYLOAD : payload_len;
			seed_q <= payload_seed;
			src_q  <= src_lo;
		end
	end

	// Byte on the wire for the current field and index
	always_comb begin
		case (state)
			ST_PREAMBLE: gmii_txd = PREAMBLE_BYTE;
			ST_SFD:      gmii_txd = SFD_BYTE;
			ST_DEST:     gmii_txd = field_byte(DEST_MAC, 3'(MAC_LEN - 1) - idx[2:0]);
			ST_SRC:      gmii_txd = field_byte({SRC_MAC_HI, src_q}, 3'(MAC_LEN - 1) - idx[2:0]);
			ST_TYPE:     gmii_txd = field_byte({32'h0, ETHERTYPE}, 3'(TYPE_LEN - 1) - idx[2:0]);
			ST_PAYLOAD:  gmii_txd = seed_q + idx;
			// FCS goes out least significant byte first
			ST_FCS:      gmii_txd = field_byte({16'h0, crc_out}, idx[2:0]);
			default:     gmii_txd = 8'h00;
		endcase
	end

	assign gmii_tx_en = (state != ST_IDLE) && (state != ST_GAP);
	// Generator never signals errors
	assign gmii_tx_er = 1'b0;
	assign frame_done = (state == ST_FCS) && field_last;

	// CRC covers header and payload, restarts at the SFD
	assign crc_clear = (state == ST_SFD);
	assign crc_en    = (state == ST_DEST) || (state == ST_SRC) ||
		(state == ST_TYPE) || (state == ST_PAYLOAD);

	eth_crc32 eth_crc32_i (
		.tx_clk    (tx_clk),
		.rst       (rst),
		.crc_clear (crc_clear),
		.crc_en    (crc_en),
		.crc_byte  (gmii_txd),
		.crc_out   (crc_out)
	);

endmodule

`default_nettype wire

// File: verilog/gmii_to_rgmii_tx.sv
// ==================================================
// GMII byte stream to RGMII DDR transmit pins
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module gmii_to_rgmii_tx (
	input  wire logic       tx_clk,
	input  wire logic       rst,
	input  wire logic [7:0] gmii_txd,
	input  wire logic       gmii_tx_en,
	input  wire logic       gmii_tx_er,
	output logic      [3:0] rgmii_txd,
	output logic            rgmii_tx_ctl,
	output logic            rgmii_tx_clk
);

	logic [7:0] txd_q;
	logic       en_q;
	logic       er_q;
	logic [3:0] hi_nib;
	logic       ctl_fall;

	// Rising-edge capture of byte and control
	always_ff @(posedge tx_clk) begin
		if (rst) begin
			en_q <= 1'b0;
			er_q <= 1'b0;
		end else begin
			en_q <= gmii_tx_en;
			er_q <= gmii_tx_er;
		end
		txd_q <= gmii_txd;
	end

	// Falling-edge half, RGMII sends en XOR er here
	always_ff @(negedge tx_clk) begin
		if (rst) begin
			ctl_fall <= 1'b0;
		end else begin
			ctl_fall <= en_q ^ er_q;
		end
		hi_nib <= txd_q[7:4];
	end

	// Output DDR mux, low nibble while the clock is high
	assign rgmii_txd    = tx_clk ? txd_q[3:0] : hi_nib;
	assign rgmii_tx_ctl = tx_clk ? en_q : ctl_fall;
	// In-phase forwarded clock
	assign rgmii_tx_clk = tx_clk;

endmodule

`default_nettype wire

// File: verilog/board_test_top.sv
// ==================================================
// Board test top, registers, frame generator, RGMII
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module board_test_top import board_pkg::*; (
	input  wire logic                 tx_clk,
	input  wire logic                 rst,
	input  wire logic                 wb_cyc,
	input  wire logic                 wb_stb,
	input  wire logic                 wb_we,
	input  wire logic [WB_ADDR_W-1:0] wb_adr,
	input  wire logic [WB_DATA_W-1:0] wb_dat_w,
	output logic      [WB_DATA_W-1:0] wb_dat_r,
	output logic                      wb_ack,
	output logic      [3:0]           rgmii_txd,
	output logic                      rgmii_tx_ctl,
	output logic                      rgmii_tx_clk,
	output logic      [7:0]           leds,
	output logic                      pmod_oe,
	output logic                      vcxo_en
);

	ctrl_reg_t            ctrl;
	logic [WB_DATA_W-1:0] period;
	logic [7:0]           src_lo;
	logic                 frame_done;
	logic                 start_tick;
	// Internal GMII transmit stream
	logic [7:0]           gmii_txd;
	logic                 gmii_tx_en;
	logic                 gmii_tx_er;

	// Host register bank and board pins
	test_regs test_regs_i (
		.tx_clk     (tx_clk),
		.rst        (rst),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.frame_done (frame_done),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.ctrl       (ctrl),
		.period     (period),
		.src_lo     (src_lo),
		.leds       (leds),
		.pmod_oe    (pmod_oe),
		.vcxo_en    (vcxo_en)
	);

	interval_timer interval_timer_i (
		.tx_clk     (tx_clk),
		.rst        (rst),
		.enable     (ctrl.fields.gen_enable),
		.period     (period),
		.start_tick (start_tick)
	);

	frame_fsm frame_fsm_i (
		.tx_clk       (tx_clk),
		.rst          (rst),
		.start_tick   (start_tick),
		.payload_len  (ctrl.fields.payload_len),
		.payload_seed (ctrl.fields.payload_seed),
		.src_lo       (src_lo),
		.gmii_txd     (gmii_txd),
		.gmii_tx_en   (gmii_tx_en),
		.gmii_tx_er   (gmii_tx_er),
		.frame_done   (frame_done)
	);

	// DDR stage to the PHY pins
	gmii_to_rgmii_tx gmii_to_rgmii_tx_i (
		.tx_clk       (tx_clk),
		.rst          (rst),
		.gmii_txd     (gmii_txd),
		.gmii_tx_en   (gmii_tx_en),
		.gmii_tx_er   (gmii_tx_er),
		.rgmii_txd    (rgmii_txd),
		.rgmii_tx_ctl (rgmii_tx_ctl),
		.rgmii_tx_clk (rgmii_tx_clk)
	);

endmodule

`default_nettype wire

// File: dv/board_test_checker.sv
// ==================================================
// Bound assertions on Wishbone ack and the GMII stream
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module board_test_checker import eth_pkg::*; (
	input wire logic tx_clk,
	input wire logic rst,
	input wire logic wb_ack,
	input wire logic start_tick,
	input wire logic gmii_tx_en,
	input wire logic gmii_tx_er
);

	logic [7:0] idle_run;

	// Idle cycles since the last frame byte, saturating
	always_ff @(posedge tx_clk) begin
		if (rst || gmii_tx_en) begin
			idle_run <= '0;
		end else if (idle_run != 8'hFF) begin
			idle_run <= idle_run + 8'd1;
		end
	end

	// Classic handshake acks each request once
	ack_single: assert property (@(posedge tx_clk) disable iff (rst)
		wb_ack |=> !wb_ack)
		else $error("Wishbone ack held for more than one cycle");

	no_tx_er: assert property (@(posedge tx_clk) disable iff (rst) !gmii_tx_er)
		else $error("GMII transmit error raised by the generator");

	// Frame begins one cycle after a tick taken in idle
	start_from_tick: assert property (@(posedge tx_clk) disable iff (rst)
		$rose(gmii_tx_en) |-> $past(start_tick))
		else $error("Frame started without a start tick");

	// FSM stays busy through the gap, ticks there are dropped
	gap_kept: assert property (@(posedge tx_clk) disable iff (rst)
		$rose(gmii_tx_en) |-> idle_run >= 8'(IFG_LEN + 1))
		else $error("Frame started inside the interframe gap");

endmodule

bind board_test_top board_test_checker board_test_checker_i (
	.tx_clk     (tx_clk),
	.rst        (rst),
	.wb_ack     (wb_ack),
	.start_tick (start_tick),
	.gmii_tx_en (gmii_tx_en),
	.gmii_tx_er (gmii_tx_er)
);

`default_nettype wire

// File: dv/board_test_tb.sv
// ==================================================
// Board test testbench for register bank and RGMII frames
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module board_test_tb import board_pkg::*, eth_pkg::*; ();

	// Tick interval shorter than the gap so ticks also land in every frame and gap
	localparam int PERIOD_CYC  = 10;
	localparam int MAX_FRAME   = 300;
	// Three content frames plus two padded and two around the latch write
	localparam int FRAME_TOTAL = 7;
	// Longest frame with its gap and one tick interval
	localparam int FRAME_CYC   = MAX_FRAME + IFG_LEN + PERIOD_CYC;
	// Idle watches and bus traffic come on top of the frames
	localparam int CYCLE_LIMIT = (FRAME_TOTAL + 3) * FRAME_CYC + 3 * (PERIOD_CYC + 50) + 2000;

	logic                 tx_clk;
	logic                 rst;
	logic                 wb_cyc;
	logic                 wb_stb;
	logic                 wb_we;
	logic [WB_ADDR_W-1:0] wb_adr;
	logic [WB_DATA_W-1:0] wb_dat_w;
	logic [WB_DATA_W-1:0] wb_dat_r;
	logic                 wb_ack;
	logic [3:0]           rgmii_txd;
	logic                 rgmii_tx_ctl;
	logic                 rgmii_tx_clk;
	logic [7:0]           leds;
	logic                 pmod_oe;
	logic                 vcxo_en;

	// Configuration the host believes is active
	ctrl_reg_t            ref_ctrl;
	logic [7:0]           ref_src;
	string                test_name = "reset";
	int                   cycles = 0;
	int                   frames_seen = 0;
	int                   frames_checked = 0;
	logic                 in_frame;
	// Captured bytes and the length and configuration of each frame
	logic [7:0]           cap_q[$];
	int                   len_q[$];
	ctrl_reg_t            ctrl_q[$];
	logic [7:0]           src_q[$];
	logic [7:0]           exp_frame [MAX_FRAME];
	int                   exp_len;

	board_test_top board_test_top_i (
		.tx_clk       (tx_clk),
		.rst          (rst),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_w     (wb_dat_w),
		.wb_dat_r     (wb_dat_r),
		.wb_ack       (wb_ack),
		.rgmii_txd    (rgmii_txd),
		.rgmii_tx_ctl (rgmii_tx_ctl),
		.rgmii_tx_clk (rgmii_tx_clk),
		.leds         (leds),
		.pmod_oe      (pmod_oe),
		.vcxo_en      (vcxo_en)
	);

	initial begin
		tx_clk = 1'b0;
		forever #4 tx_clk = ~tx_clk;
	end

	task automatic abort_run();
		$display("Something failed");
		$fatal(1, "Stopped at the first error, test %s", test_name);
	endtask

	task automatic check_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act == exp) else begin
			$display("Mismatch in %s: %s expected %h, actual %h", test_name, what, exp, act);
			abort_run();
		end
	endtask

	// One classic cycle held until ack
	task automatic wb_cycle(input logic we, input logic [WB_ADDR_W-1:0] adr,
		input logic [WB_DATA_W-1:0] dat, output logic [WB_DATA_W-1:0] rd);
		int waited;
		waited = 0;
		@(posedge tx_clk);
		#1;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		do begin
			@(posedge tx_clk);
			#1;
			waited++;
		end while (!wb_ack && waited < 16);
		assert (wb_ack) else begin
			$display("Bus access to word %0d was never acknowledged", adr);
			abort_run();
		end
		rd     = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic reg_write(input logic [WB_ADDR_W-1:0] adr, input logic [WB_DATA_W-1:0] dat);
		logic [WB_DATA_W-1:0] ignored;
		wb_cycle(1'b1, adr, dat, ignored);
	endtask

	task automatic read_check(input string what, input logic [WB_ADDR_W-1:0] adr,
		input logic [WB_DATA_W-1:0] exp);
		logic [WB_DATA_W-1:0] rd;
		wb_cycle(1'b0, adr, '0, rd);
		check_value(what, exp, rd);
	endtask

	// VCXO stays on unless the host turns it off
	task automatic check_pins();
		check_value("leds", {24'h0, ref_ctrl.fields.leds}, {24'h0, leds});
		check_value("pmod_oe", {31'h0, ref_ctrl.fields.pmod_oe}, {31'h0, pmod_oe});
		check_value("vcxo_en", {31'h0, ~ref_ctrl.fields.vcxo_off}, {31'h0, vcxo_en});
	endtask

	task automatic write_ctrl(input ctrl_reg_t c);
		ref_ctrl = c;
		reg_write(REG_CTRL, c.raw);
		check_pins();
	endtask

	function automatic ctrl_reg_t random_ctrl(input logic [7:0] len, input logic enable);
		ctrl_reg_t c;
		c.raw                = $urandom;
		c.fields.payload_len = len;
		c.fields.gen_enable  = enable;
		return c;
	endfunction

	// Serial CRC with one data bit per step LSB first
	function automatic logic [31:0] crc_update(input logic [31:0] crc_in, input logic [7:0] data);
		logic [31:0] r;
		logic        fb;
		r = crc_in;
		for (int b = 0; b < 8; b++) begin
			fb = r[0] ^ data[b];
			r  = r >> 1;
			if (fb) begin
				r = r ^ CRC_POLY;
			end
		end
		return r;
	endfunction

	// Expected wire bytes from preamble through FCS
	function automatic void build_frame(input ctrl_reg_t cfg, input logic [7:0] src);
		logic [47:0] src_mac;
		logic [31:0] crc;
		int          len;
		int          n;
		src_mac = {SRC_MAC_HI, src};
		len = (cfg.fields.payload_len < MIN_PAYLOAD) ? int'(MIN_PAYLOAD) :
			int'(cfg.fields.payload_len);
		n = 0;
		for (int i = 0; i < PREAMBLE_LEN; i++) begin
			exp_frame[n] = PREAMBLE_BYTE;
			n++;
		end
		exp_frame[n] = SFD_BYTE;
		n++;
		// Addresses go out most significant byte first
		for (int i = 0; i < MAC_LEN; i++) begin
			exp_frame[n]           = DEST_MAC[47 - 8 * i -: 8];
			exp_frame[n + MAC_LEN] = src_mac[47 - 8 * i -: 8];
			n++;
		end
		n += MAC_LEN;
		exp_frame[n]     = ETHERTYPE[15:8];
		exp_frame[n + 1] = ETHERTYPE[7:0];
		n += TYPE_LEN;
		for (int k = 0; k < len; k++) begin
			exp_frame[n] = cfg.fields.payload_seed + 8'(k);
			n++;
		end
		// CRC starts after the SFD
		crc = CRC_INIT;
		for (int i = PREAMBLE_LEN + 1; i < n; i++) begin
			crc = crc_update(crc, exp_frame[i]);
		end
		crc = ~crc;
		for (int i = 0; i < FCS_LEN; i++) begin
			exp_frame[n] = crc[8 * i +: 8];
			n++;
		end
		exp_len = n;
	endfunction

	task automatic wait_frames(input int n);
		int target;
		target = frames_checked + n;
		while (frames_checked < target) @(posedge tx_clk);
		#1;
	endtask

	// Line must stay idle once the running frame has ended
	task automatic stop_generator();
		ctrl_reg_t c;
		c = ref_ctrl;
		c.fields.gen_enable = 1'b0;
		write_ctrl(c);
		repeat (4) @(posedge tx_clk);
		while (in_frame) @(posedge tx_clk);
		repeat (PERIOD_CYC + 50) begin
			@(posedge tx_clk);
			#1;
			assert (!rgmii_tx_ctl) else begin
				$display("A frame was sent while the generator was disabled");
				abort_run();
			end
		end
		check_value("frames compared", 32'(frames_seen), 32'(frames_checked));
		read_check("frame count", REG_FRAME_CNT, 32'(frames_seen));
	endtask

	// Low nibble sampled mid high phase and high nibble mid low phase
	initial begin : capture_rgmii
		logic [3:0] lo;
		logic [3:0] hi;
		logic       ctl_r;
		logic       ctl_f;
		logic       clk_r;
		logic       clk_f;
		int         n;
		in_frame = 1'b0;
		n = 0;
		forever begin
			@(posedge tx_clk);
			#2;
			lo    = rgmii_txd;
			ctl_r = rgmii_tx_ctl;
			clk_r = rgmii_tx_clk;
			@(negedge tx_clk);
			#2;
			hi    = rgmii_txd;
			ctl_f = rgmii_tx_ctl;
			clk_f = rgmii_tx_clk;
			// Forwarded clock follows tx_clk in phase
			assert (clk_r === 1'b1 && clk_f === 1'b0) else begin
				$display("RGMII transmit clock is not in phase with tx_clk");
				abort_run();
			end
			// Without error coding both halves carry tx_en
			assert (rst || ctl_r === ctl_f) else begin
				$display("RGMII control differs between the two clock edges");
				abort_run();
			end
			if (ctl_r === 1'b1) begin
				if (!in_frame) begin
					ctrl_q.push_back(ref_ctrl);
					src_q.push_back(ref_src);
				end
				cap_q.push_back({hi, lo});
				in_frame = 1'b1;
				n++;
			end else if (in_frame) begin
				len_q.push_back(n);
				frames_seen++;
				in_frame = 1'b0;
				n = 0;
			end
		end
	end

	initial begin : compare_frames
		logic [7:0]  got;
		logic [31:0] crc;
		int          n;
		forever begin
			@(posedge tx_clk);
			while (len_q.size() > 0) begin
				n = len_q.pop_front();
				build_frame(ctrl_q.pop_front(), src_q.pop_front());
				assert (n == exp_len) else begin
					$display("Mismatch in %s: frame length expected %0d, actual %0d",
						test_name, exp_len, n);
					abort_run();
				end
				crc = CRC_INIT;
				for (int i = 0; i < n; i++) begin
					got = cap_q.pop_front();
					assert (got == exp_frame[i]) else begin
						$display("Mismatch in %s: byte %0d expected %h, actual %h",
							test_name, i, exp_frame[i], got);
						abort_run();
					end
					if (i > PREAMBLE_LEN) begin
						crc = crc_update(crc, got);
					end
				end
				// Data plus FCS leaves the fixed residue
				assert (crc == CRC_RESIDUE) else begin
					$display("Mismatch in %s: CRC residue expected %h, actual %h",
						test_name, CRC_RESIDUE, crc);
					abort_run();
				end
				frames_checked++;
			end
		end
	end

	initial begin : watchdog
		forever begin
			@(posedge tx_clk);
			cycles++;
			if (cycles > CYCLE_LIMIT) begin
				$display("Timeout after %0d cycles, test %s did not finish", cycles, test_name);
				abort_run();
			end
		end
	end

	initial begin : run_tests
		ctrl_reg_t            c;
		logic [WB_DATA_W-1:0] val;
		void'($urandom(36026));
		rst      = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		ref_ctrl = '0;
		ref_src  = SRC_LO_RESET;
		repeat (2) @(posedge tx_clk);
		#1;
		rst = 1'b0;

		read_check("CTRL after reset", REG_CTRL, '0);
		read_check("PERIOD after reset", REG_PERIOD, PERIOD_RESET);
		read_check("SRC_LO after reset", REG_SRC_LO, {24'h0, SRC_LO_RESET});
		read_check("frame count after reset", REG_FRAME_CNT, '0);
		read_check("ID", REG_ID, BOARD_ID);
		read_check("unmapped word", 4'd9, '0);
		check_pins();

		test_name = "register access";
		repeat (4) begin
			c = random_ctrl(8'($urandom), 1'b0);
			write_ctrl(c);
			read_check("CTRL", REG_CTRL, c.raw);
			val = $urandom;
			reg_write(REG_PERIOD, val);
			read_check("PERIOD", REG_PERIOD, val);
			ref_src = 8'($urandom);
			reg_write(REG_SRC_LO, {24'h0, ref_src});
			read_check("SRC_LO", REG_SRC_LO, {24'h0, ref_src});
			// ID is read only
			reg_write(REG_ID, val);
			read_check("ID after write", REG_ID, BOARD_ID);
		end
		reg_write(REG_PERIOD, 32'(PERIOD_CYC - 1));

		test_name = "frame content";
		write_ctrl(random_ctrl(8'($urandom_range(255, 46)), 1'b1));
		wait_frames(3);
		stop_generator();

		test_name = "short length padding";
		write_ctrl(random_ctrl(8'($urandom_range(45, 0)), 1'b1));
		wait_frames(2);
		stop_generator();

		// New setup lands mid frame and only the next frame may use it
		test_name = "configuration latch";
		write_ctrl(random_ctrl(8'($urandom_range(255, 46)), 1'b1));
		while (!in_frame) @(posedge tx_clk);
		repeat (10) @(posedge tx_clk);
		c = random_ctrl(8'($urandom_range(255, 0)), 1'b1);
		c.fields.payload_seed = ref_ctrl.fields.payload_seed ^ 8'h5A;
		write_ctrl(c);
		wait_frames(2);
		stop_generator();

		test_name = "end of run";
		if (frames_checked == FRAME_TOTAL) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("Expected %0d frames in total, compared %0d", FRAME_TOTAL, frames_checked);
			abort_run();
		end
	end

endmodule

`default_nettype wire

// File: flist.f
common/board_pkg.sv
common/eth_pkg.sv
verilog/test_regs.sv
frame_gen/interval_timer.sv
frame_gen/eth_crc32.sv
frame_gen/frame_fsm.sv
verilog/gmii_to_rgmii_tx.sv
verilog/board_test_top.sv
dv/board_test_checker.sv
dv/board_test_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := board_test_tb
RTL_TOP    := board_test_top
FLIST      := flist.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# Exit status of the simulation is the pass or fail result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
